/* hdl/instrIssue.sv */
// Instruction issue: accepts words on a four-phase req/ack port and pushes them into the queue
`timescale 1ns/1ps
`default_nettype none

module instrIssue (
	input  logic				clk,
	input  logic				reset,
	input  logic				inReq,		// Four-phase request from outside
	input  uopPkg::instrWord	inInstr,	// Stable while inReq high
	output logic				inAck,
	input  logic				full,		// Queue back-pressure
	output logic				push,		// One-cycle write strobe
	output uopPkg::instrWord	pushData
);

	// Handshake tracker states
	typedef enum logic {
		issueIdle,	// Waiting for a request with room in the queue
		issueAcked	// Word written, waiting for inReq to drop
	} issueState;

	issueState state;
	logic takeWord;		// Request seen and queue has room

	// A held request simply waits here while the queue is full
	assign takeWord = (state == issueIdle) && inReq && !full;

	// Ack is the state itself, so it rises together with push
	assign inAck = (state == issueAcked);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= issueIdle;
			push <= 1'b0;
		end else begin
			push <= takeWord;	// Strobe lasts one cycle, state leaves idle
			case (state)
				issueIdle: begin
					if (takeWord)
						state <= issueAcked;	// Exactly one write per request
				end
				issueAcked: begin
					if (!inReq)
						state <= issueIdle;	// Drop ack, cycle complete
				end
				default: state <= issueIdle;
			endcase
		end
	end

	// Payload capture, no reset needed
	always_ff @(posedge clk) begin
		if (takeWord)
			pushData <= inInstr;	// Held until the queue samples push
	end

endmodule

`default_nettype wire

/* hdl/instrQueue.sv */
// Instruction queue: circular FIFO of instruction words with full and empty flags
`timescale 1ns/1ps
`default_nettype none

module instrQueue #(
	parameter int depth = 4
) (
	input  logic				clk,
	input  logic				reset,
	input  logic				push,		// Write strobe from issue
	input  logic				pop,		// Read strobe from sequencer
	input  uopPkg::instrWord	pushData,
	output uopPkg::instrWord	headData,	// Oldest entry
	output logic				full,
	output logic				empty
);

	import uopPkg::*;

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	instrWord mem [depth];				// Storage, no reset
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;		// Occupancy, 0 to depth
	logic doPush;
	logic doPop;

	// Wrap at depth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		logic [ptrWidth-1:0] result;
		if (ptr == ptrWidth'(depth - 1))
			result = '0;
		else
			result = ptr + 1'b1;
		return result;
	endfunction

	assign full = (count == countWidth'(depth));
	assign empty = (count == '0);
	assign headData = mem[rdPtr];		// Head visible as soon as it is written

	// Strobes outside the flags are ignored
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither, no change
			endcase
		end
	end

	// Entry write
	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

`default_nettype wire

/* hdl/uopPkg.sv */
// Shared types for the micro-op expansion path: instruction word, micro-op and FSM encodings
`default_nettype none

package uopPkg;

	// One ARM instruction word as it moves through issue, queue and sequencer
	typedef logic [31:0] instrWord;

	// Default number of queue entries between issue and sequencer
	localparam int defaultQueueDepth = 4;

	// Data-processing opcode field, bits 24 to 21
	typedef enum logic [3:0] {
		andOp = 4'h0,	// Rd = Rn AND op2
		eorOp = 4'h1,	// Exclusive or
		subOp = 4'h2,
		rsbOp = 4'h3,	// Reverse subtract
		addOp = 4'h4,
		adcOp = 4'h5,	// Add with carry
		sbcOp = 4'h6,
		rscOp = 4'h7,
		tstOp = 4'h8,	// Compare ops only touch flags
		teqOp = 4'h9,
		cmpOp = 4'ha,
		cmnOp = 4'hb,
		orrOp = 4'hc,
		movOp = 4'hd,	// Used for the Rz load of an RSR pair
		bicOp = 4'he,
		mvnOp = 4'hf
	} dpOpcode;

	// Sequencer FSM states
	typedef enum logic {
		seqReady,		// Idle, or presenting an ordinary or first micro-op
		seqRsrSecond	// Presenting second half of an RSR pair
	} seqState;

	// One micro-op as it leaves the sequencer, 39 bits
	typedef struct packed {
		instrWord		instr;			// Micro-op instruction word
		logic			raMuxSel;		// Rz on first read-address mux
		logic [2:0]		rzSel;			// Rz select for WA3, RA2 and RA1
		logic			noFlagUpdate;	// Suppress flag write
		logic			fromRsr;		// Produced by an RSR expansion
		logic			rsrSecond;		// Second half of a pair
	} uopPacket;

endpackage

`default_nettype wire

/* hdl/uopSequencer.sv */
// Micro-op sequencer: reads the queue, splits RSR instructions in two and drives the output port
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input  logic				clk,
	input  logic				reset,
	input  logic				empty,		// Queue has no word
	input  uopPkg::instrWord	headData,	// Oldest queue entry
	output logic				pop,		// One-cycle read strobe
	output logic				uopReq,		// Four-phase request to outside
	input  logic				uopAck,
	output uopPkg::uopPacket	uopOut		// Valid while uopReq high
);

	import uopPkg::*;

	seqState state;
	instrWord instrReg;		// Word being expanded
	logic ackPending;		// Req dropped, waiting for ack low
	logic takeHead;			// Read the next queue word
	logic rsrInstr;			// instrReg is register-shifted-register

	// Data-processing with shift by register: 27..25 zero, bit 7 zero, bit 4 one
	function automatic logic isRsr(input instrWord w);
		return (w[27:25] == 3'b000) && !w[7] && w[4];
	endfunction

	assign rsrInstr = isRsr(instrReg);

	// New word only with the port fully idle
	assign takeHead = (state == seqReady) && !uopReq && !ackPending && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seqReady;
			uopReq <= 1'b0;
			ackPending <= 1'b0;
			pop <= 1'b0;
		end else begin
			pop <= takeHead;			// Queue drops head next edge
			if (uopReq) begin
				if (uopAck) begin
					uopReq <= 1'b0;		// Phase 3 of the handshake
					ackPending <= 1'b1;
					if (state == seqRsrSecond)
						state <= seqReady;	// Pair finished
					else if (rsrInstr)
						state <= seqRsrSecond;	// First half accepted
				end
			end else if (ackPending) begin
				if (!uopAck) begin
					ackPending <= 1'b0;
					if (state == seqRsrSecond)
						uopReq <= 1'b1;	// Second half, no queue read
				end
			end else if (takeHead) begin
				uopReq <= 1'b1;			// Ordinary or first micro-op
			end
		end
	end

	// Latched word, no reset
	always_ff @(posedge clk) begin
		if (takeHead)
			instrReg <= headData;
	end

	// Micro-op fields from state and latched word
	always_comb begin
		uopOut = '0;
		uopOut.instr = instrReg;			// Pass-through by default
		if (rsrInstr) begin
			uopOut.fromRsr = 1'b1;
			if (state == seqReady) begin
				// MOV Rz, Rm shift Rs without flag update
				uopOut.instr = {instrReg[31:25],	// Cond and class bits
					movOp, 1'b0,					// Opcode and S clear
					4'b0000, 4'b0000,				// Rn and Rd map to Rz
					instrReg[11:0]};				// Shift operand
				uopOut.raMuxSel = 1'b1;
				uopOut.rzSel = 3'b100;			// Rz on write address
				uopOut.noFlagUpdate = 1'b1;
			end else begin
				// Original op reading Rz as operand 2
				uopOut.instr = {instrReg[31:12], 12'b0};
				uopOut.rzSel = 3'b010;			// Rz on second read address
				uopOut.rsrSecond = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/uopTop.sv */
// Micro-op expansion stage: issue, instruction queue and sequencer between two req/ack ports
`timescale 1ns/1ps
`default_nettype none

module uopTop #(
	parameter int queueDepth = uopPkg::defaultQueueDepth
) (
	input  logic				clk,
	input  logic				reset,
	input  logic				inReq,		// Instruction port
	input  uopPkg::instrWord	inInstr,
	output logic				inAck,
	output logic				uopReq,		// Micro-op port
	input  logic				uopAck,
	output uopPkg::uopPacket	uopOut
);

	import uopPkg::*;

	logic push;
	logic pop;
	logic full;
	logic empty;
	instrWord pushData;		// Issue to queue
	instrWord headData;		// Queue head to sequencer

	instrIssue issue0 (
		.clk		(clk),
		.reset		(reset),
		.inReq		(inReq),
		.inInstr	(inInstr),
		.inAck		(inAck),
		.full		(full),
		.push		(push),
		.pushData	(pushData)
	);

	instrQueue #(
		.depth		(queueDepth)
	) queue0 (
		.clk		(clk),
		.reset		(reset),
		.push		(push),
		.pop		(pop),
		.pushData	(pushData),
		.headData	(headData),
		.full		(full),
		.empty		(empty)
	);

	uopSequencer seq0 (
		.clk		(clk),
		.reset		(reset),
		.empty		(empty),
		.headData	(headData),
		.pop		(pop),
		.uopReq		(uopReq),
		.uopAck		(uopAck),
		.uopOut		(uopOut)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the micro-op stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module uopTb -o uopSim

# Exit status of the simulation is the test result
./obj_dir/uopSim

/* tb.f */
hdl/uopPkg.sv
hdl/instrIssue.sv
hdl/instrQueue.sv
hdl/uopSequencer.sv
hdl/uopTop.sv
test/uopTop_checker.sv
test/uopTb.sv

/* test/uopTb.sv */
// Testbench for the micro-op expansion stage with file-driven words, random ack delays and a scoreboard
`timescale 1ns/1ps
`default_nettype none

module uopTb;

	import uopPkg::*;

	localparam int queueDepth = defaultQueueDepth;
	localparam int resetCycles = 5;
	localparam int cyclesPerLine = 40;	// Watchdog budget per stimulus line
	localparam int stallAt = 6;			// Micro-op whose ack is held back
	localparam int stallCycles = 40;	// Long enough to fill the queue

	logic clk;
	logic reset;
	logic inReq;
	instrWord inInstr;
	logic inAck;
	logic uopReq;
	logic uopAck;
	uopPacket uopOut;

	// Stimulus table with one entry per file line
	string nameList[$];
	instrWord wordList[$];
	int countList[$];
	uopPacket firstList[$];
	uopPacket secondList[$];
	int expectedTotal;

	// Scoreboard filled by the input driver in send order
	uopPacket expectQ[$];
	string expectName[$];

	int receivedCount;		// Micro-ops seen on the output port
	int acceptedCount;		// Words acked on the input port
	int startedCount;		// Words whose first micro-op has appeared
	logic [31:0] lcgState;
	logic prevReq;
	bit stimulusLoaded = 1'b0;

	uopTop #(
		.queueDepth	(queueDepth)
	) dut0 (
		.clk		(clk),
		.reset		(reset),
		.inReq		(inReq),
		.inInstr	(inInstr),
		.inAck		(inAck),
		.uopReq		(uopReq),
		.uopAck		(uopAck),
		.uopOut		(uopOut)
	);

	bind uopTop uopTop_checker checker0 (
		.clk		(clk),
		.reset		(reset),
		.inReq		(inReq),
		.inAck		(inAck),
		.uopReq		(uopReq),
		.uopAck		(uopAck),
		.uopOut		(uopOut)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;		// 10 ns period
	end

	task automatic stopRun;
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic reportError(input string reason);
		$display("ERROR %s", reason);
		stopRun();
	endtask

	task automatic compareUop(input string testName, input uopPacket expected,
			input uopPacket actual);
		if (actual !== expected) begin
			// Word then raMuxSel rzSel noFlagUpdate fromRsr rsrSecond
			$display("MISMATCH %s expected %h/%b actual %h/%b", testName,
				expected.instr, expected[6:0], actual.instr, actual[6:0]);
			stopRun();
		end
	endtask

	task automatic compareCount(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			$display("MISMATCH %s expected %0d actual %0d", testName, expected, actual);
			stopRun();
		end
	endtask

	task automatic compareLevel(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %b actual %b", testName, expected, actual);
			stopRun();
		end
	endtask

	// Inputs change and outputs are read 1 ns after the rising edge
	task automatic waitCycle;
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Wait 0 to 7 cycles taken from upper LCG bits
	task automatic randomDelay;
		lcgState = lcgStep(lcgState);
		repeat (int'(lcgState[26:24])) waitCycle();
	endtask

	task automatic loadStimulus;
		int fd;
		int code;
		int fields;
		int count;
		string line;
		string name;
		instrWord word;
		instrWord firstInstr;
		instrWord secondInstr;
		logic [6:0] firstCtrl;
		logic [6:0] secondCtrl;
		fd = $fopen("test/uop_stimulus.txt", "r");
		if (fd == 0)
			reportError("cannot open the stimulus file test/uop_stimulus.txt");
		expectedTotal = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;		// Blank or comment line
			fields = $sscanf(line, "%s %h %d %h %b %h %b", name, word, count,
				firstInstr, firstCtrl, secondInstr, secondCtrl);
			if (fields != 7)
				reportError({"stimulus line has the wrong number of columns: ", line});
			if (count != 1 && count != 2)
				reportError({"stimulus line has a micro-op count other than 1 or 2: ", line});
			nameList.push_back(name);
			wordList.push_back(word);
			countList.push_back(count);
			firstList.push_back(uopPacket'({firstInstr, firstCtrl}));
			secondList.push_back(uopPacket'({secondInstr, secondCtrl}));
			expectedTotal += count;
		end
		$fclose(fd);
		if (nameList.size() == 0)
			reportError("stimulus file holds no test lines");
	endtask

	// One four-phase cycle on the input port
	task automatic sendInstr(input int idx);
		if (countList[idx] == 2) begin
			expectQ.push_back(firstList[idx]);
			expectName.push_back({nameList[idx], "First"});
			expectQ.push_back(secondList[idx]);
			expectName.push_back({nameList[idx], "Second"});
		end else begin
			expectQ.push_back(firstList[idx]);
			expectName.push_back(nameList[idx]);
		end
		inInstr = wordList[idx];
		inReq = 1'b1;
		while (!inAck)
			waitCycle();		// Stalls here while the queue is full
		acceptedCount++;
		inReq = 1'b0;
		while (inAck)
			waitCycle();
	endtask

	initial begin
		reset = 1'b1;
		inReq = 1'b0;
		inInstr = '0;
		uopAck = 1'b0;
		lcgState = 32'h0eaa58e7;
		receivedCount = 0;
		acceptedCount = 0;
		startedCount = 0;
		loadStimulus();
		stimulusLoaded = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		// Port stays quiet with no request
		repeat (4) waitCycle();
		compareLevel("idleUopReq", 1'b0, uopReq);
		compareLevel("idleInAck", 1'b0, inAck);
		compareCount("idleUops", 0, receivedCount);
		for (int i = 0; i < nameList.size(); i++)
			sendInstr(i);
		while (receivedCount < expectedTotal)
			waitCycle();
		while (uopReq || uopAck)
			waitCycle();
		repeat (20) waitCycle();	// Any duplicate would show up here
		compareCount("totalUops", expectedTotal, receivedCount);
		compareCount("scoreboardLeft", 0, expectQ.size());
		$display("SIMULATION PASSED");
		$finish;
	end

	// Each rise of uopReq is one micro-op
	initial begin : uopMonitor
		uopPacket expected;
		string name;
		prevReq = 1'b0;
		forever begin
			waitCycle();
			if (uopReq && !prevReq) begin
				receivedCount++;
				if (expectQ.size() != 0) begin
					expected = expectQ.pop_front();
					name = expectName.pop_front();
					compareUop(name, expected, uopOut);
				end
				if (!uopOut.rsrSecond)
					startedCount++;		// New word entered the sequencer
			end
			prevReq = uopReq;
		end
	end

	// Four-phase responder on the micro-op port
	initial begin : uopResponder
		int uopIndex;
		int backlog;
		uopIndex = 0;
		forever begin
			waitCycle();
			if (uopReq) begin
				uopIndex++;
				if (uopIndex == stallAt) begin
					repeat (stallCycles) waitCycle();	// Queue fills behind this one
					backlog = nameList.size() - startedCount;
					if (backlog > queueDepth) begin
						compareLevel("stallInAck", 1'b0, inAck);
						backlog = queueDepth;
					end
					compareCount("stallBacklog", backlog, acceptedCount - startedCount);
				end else begin
					randomDelay();
				end
				uopAck = 1'b1;
				while (uopReq)
					waitCycle();
				randomDelay();
				uopAck = 1'b0;
			end
		end
	end

	initial begin : watchdog
		int budget;
		wait (stimulusLoaded);
		budget = resetCycles + stallCycles + cyclesPerLine * nameList.size();
		repeat (budget) @(posedge clk);
		reportError($sformatf("timeout after %0d cycles, micro-ops did not drain", budget));
	end

endmodule

`default_nettype wire

/* test/uopTop_checker.sv */
// Handshake and RSR pairing assertions for the micro-op stage, bound into uopTop
`timescale 1ns/1ps
`default_nettype none

module uopTop_checker (
	input  logic				clk,
	input  logic				reset,
	input  logic				inReq,
	input  logic				inAck,
	input  logic				uopReq,
	input  logic				uopAck,
	input  uopPkg::uopPacket	uopOut
);

	logic prevReq;		// uopReq one cycle back
	logic pairOpen;		// First half of a pair was the last micro-op
	logic newUop;

	assign newUop = uopReq && !prevReq;

	always_ff @(posedge clk) begin
		if (reset) begin
			prevReq <= 1'b0;
			pairOpen <= 1'b0;
		end else begin
			prevReq <= uopReq;
			if (newUop)
				pairOpen <= uopOut.fromRsr && !uopOut.rsrSecond;
		end
	end

	// Request held until ack
	assert property (@(posedge clk) disable iff (reset) (uopReq && !uopAck) |=> uopReq)
		else $error("uopReq dropped before uopAck");

	// Payload steady while waiting
	assert property (@(posedge clk) disable iff (reset) (uopReq && !uopAck) |=> $stable(uopOut))
		else $error("uopOut changed while uopReq waited for uopAck");

	assert property (@(posedge clk) disable iff (reset) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose without inReq");

	assert property (@(posedge clk) reset |=> (!uopReq && !inAck))
		else $error("uopReq or inAck high during reset");

	// Second half exactly after a first half
	assert property (@(posedge clk) disable iff (reset) newUop |-> (uopOut.rsrSecond == pairOpen))
		else $error("RSR micro-op pairing broken");

	assert property (@(posedge clk) disable iff (reset)
			(newUop && uopOut.rsrSecond) |-> uopOut.fromRsr)
		else $error("second half without fromRsr");

endmodule

`default_nettype wire

/* test/uop_stimulus.txt */
# name  inWord  uopCount  uop1Instr  uop1Ctrl  uop2Instr  uop2Ctrl
# Ctrl bits: raMuxSel rzSel[2:0] noFlagUpdate fromRsr rsrSecond; unused uop2 columns are zero
addImm E2821005 1 E2821005 0000000 00000000 0000000
movLslImm E1A03104 1 E1A03104 0000000 00000000 0000000
addRsr E0821413 2 E1A00413 1100110 E0821000 0010011
mul E0000291 1 E0000291 0000000 00000000 0000000
subsRsrNe 10565857 2 11A00857 1100110 10565000 0010011
addsLsrImm E09100A2 1 E09100A2 0000000 00000000 0000000
orrRsr E18A9C7B 2 E1A00C7B 1100110 E18A9000 0010011
branch EA000010 1 EA000010 0000000 00000000 0000000
cmpRsr E1510332 2 E1A00332 1100110 E1510000 0010011
ldrImm E5910004 1 E5910004 0000000 00000000 0000000
bicRsrEq 01C54716 2 01A00716 1100110 01C54000 0010011
mvnImm E3E000FF 1 E3E000FF 0000000 00000000 0000000
eorReg E0211001 1 E0211001 0000000 00000000 0000000
movRsr E1A02413 2 E1A00413 1100110 E1A02000 0010011
rsbsRsrGt C0721433 2 C1A00433 1100110 C0721000 0010011
subImm E2400001 1 E2400001 0000000 00000000 0000000
andRsr E0043615 2 E1A00615 1100110 E0043000 0010011
tstImm E3110008 1 E3110008 0000000 00000000 0000000
adcsRsrCs 20B87A79 2 21A00A79 1100110 20B87000 0010011
strImm E5832000 1 E5832000 0000000 00000000 0000000
cmnReg E1710002 1 E1710002 0000000 00000000 0000000
eorRsr E0200231 2 E1A00231 1100110 E0200000 0010011
